//--- hdl/dptx_pkg.sv
/*
    DisplayPort TX link package
    Link geometry, symbol codes, control message IDs and register
    indices, plus the symbol bundle types shared by the link data path
*/

`default_nettype none

package dptx_pkg;

    // Link geometry
    localparam int lanes    = 4;    // Physical lanes
    localparam int spl      = 2;    // Symbols per lane per clock
    localparam int sym_w    = 8;    // Bits per symbol
    localparam int tps2_len = 10;   // TPS2 cycle length in symbols

    // Message word
    localparam int msg_w = 16;

    // Message ID of the control block
    localparam logic [7:0] msg_id_ctl = 8'h10;

    // Control register indices
    localparam logic [7:0] reg_lanes   = 8'd0;  // Active lanes
    localparam logic [7:0] reg_trn_sel = 8'd1;  // Training select
    localparam logic [7:0] reg_scrm_en = 8'd2;  // Scrambler enable
    localparam logic [7:0] reg_tps_sel = 8'd3;  // TPS1 / TPS2

    // Symbol codes
    localparam logic [7:0] sym_bs    = 8'hBC;   // K28.5
    localparam logic [7:0] sym_sr    = 8'h1C;   // K28.0, scrambler reset
    localparam logic [7:0] sym_d10_2 = 8'h4A;   // D10.2
    localparam logic [7:0] sym_d11_6 = 8'hCB;   // D11.6

    // Scrambler LFSR seed
    localparam logic [15:0] scrm_seed = 16'hFFFF;

    // All symbols of one clock, flat index lane * spl + symbol
    typedef logic [lanes*spl-1:0][sym_w-1:0] lane_dat_t;

    // K flag per symbol, same indexing
    typedef logic [lanes*spl-1:0] lane_k_t;

    // One message word, raw value or header view
    typedef union packed {
        logic [msg_w-1:0] dat;      // Value word
        struct packed {
            logic [7:0] id;         // Target block
            logic [7:0] idx;        // Register index
        } hdr;
    } msg_word_u;

endpackage

`default_nettype wire

//--- hdl/dptx_ctl_if.sv
/*
    DisplayPort TX link control interface
    Carries the link settings as levels from the control block
    to scrambler, training generator and lane output stage
*/

`default_nettype none

interface dptx_ctl_if;

    logic [1:0] lanes;      // 1 - one lane, 2 - two lanes, 3 - four lanes
    logic       trn_sel;    // 1 - training, 0 - main link
    logic       scrm_en;    // Scrambler enable
    logic       tps_sel;    // 0 - TPS1, 1 - TPS2

    // Register owner
    modport ctl (output lanes, output trn_sel, output scrm_en, output tps_sel);

    modport scrm (input scrm_en);

    modport trn (input tps_sel, input trn_sel);

    // Lane output stage
    modport out (input lanes, input trn_sel);

endinterface

`default_nettype wire

//--- hdl/dptx_msg_ctl.sv
/*
    DisplayPort TX link control
    Parses two-word control messages (header, value) and holds
    the link settings registers
*/

`default_nettype none

module dptx_msg_ctl
    import dptx_pkg::*;
(
    input  logic        lnk_clk,
    input  logic        rst,

    // Message
    input  logic        msg_som,    // Start of message
    input  logic        msg_eom,    // End of message
    input  logic        msg_vld,    // Word valid
    input  msg_word_u   msg_dat,

    // Settings
    dptx_ctl_if.ctl     ctl
);

logic       val_wait;   // Control header taken, value pending
logic [7:0] idx_r;      // Register named by the header

// Register index from the header
always_ff @(posedge lnk_clk)
begin
    if (msg_vld && msg_som)
        idx_r <= msg_dat.hdr.idx;
end

// Parser and settings registers
always_ff @(posedge lnk_clk)
begin
    if (rst)
    begin
        val_wait    <= 1'b0;
        ctl.lanes   <= 2'd3;    // Four lanes
        ctl.trn_sel <= 1'b1;    // Start in training
        ctl.scrm_en <= 1'b0;
        ctl.tps_sel <= 1'b0;    // TPS1
    end

    else if (msg_vld)
    begin
        // Header; other IDs park the parser until next som
        if (msg_som)
            val_wait <= (msg_dat.hdr.id == msg_id_ctl) && !msg_eom;

        // Value word
        else if (val_wait)
        begin
            val_wait <= 1'b0;   // One value per header

            case (idx_r)
                reg_lanes   : ctl.lanes   <= msg_dat.dat[1:0];
                reg_trn_sel : ctl.trn_sel <= msg_dat.dat[0];
                reg_scrm_en : ctl.scrm_en <= msg_dat.dat[0];
                reg_tps_sel : ctl.tps_sel <= msg_dat.dat[0];
                default     : ;     // Unknown index, no write
            endcase
        end

        // Words outside a control message are dropped here
    end
end

endmodule

`default_nettype wire

//--- hdl/dptx_scrm.sv
/*
    DisplayPort TX main-link scrambler
    One 16-bit LFSR per lane, spl symbols per clock handled in order.
    Data symbols XOR with the scramble byte when enabled, K symbols
    pass, SR brings the LFSR back to the seed. One cycle latency
*/

`default_nettype none

module dptx_scrm
    import dptx_pkg::*;
(
    input  logic        lnk_clk,
    input  logic        rst,

    // Control
    dptx_ctl_if.scrm    ctl,

    // Main link in
    input  lane_dat_t   main_dat,
    input  lane_k_t     main_k,

    // Scrambled out
    output lane_dat_t   scrm_dat,
    output lane_k_t     scrm_k
);

// Next symbols per lane
logic [spl-1:0][sym_w-1:0] dat_nxt [lanes];

for (genvar l = 0; l < lanes; l++)
begin : gen_lane
    logic [15:0] lfsr_r;
    logic [15:0] lfsr_nxt;

    // Chain of spl symbol steps within the clock
    always_comb
    begin
        logic [15:0]      s;
        logic [sym_w-1:0] sb;
        logic [sym_w-1:0] d;

        s  = lfsr_r;
        sb = '0;
        d  = '0;

        for (int j = 0; j < spl; j++)
        begin
            d = main_dat[l*spl+j];

            // Eight LFSR steps, step k gives scramble bit k
            for (int k = 0; k < sym_w; k++)
            begin
                sb[k] = s[15];
                s     = {s[14:0], s[15]} ^ {10'd0, {3{s[15]}}, 3'd0};  // Taps 3, 4, 5
            end

            if (main_k[l*spl+j])
            begin
                dat_nxt[l][j] = d;      // K symbols unchanged
                if (d == sym_sr)
                    s = scrm_seed;      // Restart before next symbol
            end

            else
                dat_nxt[l][j] = ctl.scrm_en ? (d ^ sb) : d;
        end

        lfsr_nxt = s;
    end

    // Lane LFSR
    always_ff @(posedge lnk_clk)
    begin
        if (rst)
            lfsr_r <= scrm_seed;
        else
            lfsr_r <= lfsr_nxt;
    end
end

// Output register, flat symbol order
always_ff @(posedge lnk_clk)
begin
    for (int l = 0; l < lanes; l++)
    begin
        for (int j = 0; j < spl; j++)
            scrm_dat[l*spl+j] <= dat_nxt[l][j];
    end

    scrm_k <= main_k;   // K flags ride along
end

endmodule

`default_nettype wire

//--- hdl/dptx_trn.sv
/*
    DisplayPort TX training pattern generator
    TPS1 is D10.2 throughout. TPS2 runs a 10-symbol cycle
    (BS D11.6 BS D11.6 then six D10.2), same on every lane
*/

`default_nettype none

module dptx_trn
    import dptx_pkg::*;
(
    input  logic        lnk_clk,
    input  logic        rst,

    // Control
    dptx_ctl_if.trn     ctl,

    // Pattern out
    output lane_dat_t   trn_dat,
    output lane_k_t     trn_k
);

logic       trn_sel_d;  // Previous training select
logic       tps_sel_d;  // Previous pattern select
logic [3:0] pos_r;      // TPS2 position of next pair
logic [3:0] pos_cur;    // Position used this clock
logic       restart;

// TPS2 symbol at a cycle position, {k, dat}
function automatic logic [sym_w:0] tps2_sym(input logic [3:0] pos);
    case (pos)
        4'd0, 4'd2 : return {1'b1, sym_bs};
        4'd1, 4'd3 : return {1'b0, sym_d11_6};
        default    : return {1'b0, sym_d10_2};
    endcase
endfunction

always_comb
begin
    restart = (ctl.trn_sel && !trn_sel_d) || (ctl.tps_sel != tps_sel_d);
    pos_cur = restart ? 4'd0 : pos_r;
end

// Position counter, steps of spl
always_ff @(posedge lnk_clk)
begin
    if (rst)
    begin
        trn_sel_d <= 1'b0;
        tps_sel_d <= 1'b0;
        pos_r     <= '0;
    end

    else
    begin
        trn_sel_d <= ctl.trn_sel;
        tps_sel_d <= ctl.tps_sel;
        pos_r     <= (pos_cur + spl >= tps2_len) ? 4'd0 : pos_cur + 4'(spl);
    end
end

// Registered pattern, identical on all lanes
always_ff @(posedge lnk_clk)
begin
    for (int l = 0; l < lanes; l++)
    begin
        for (int j = 0; j < spl; j++)
        begin
            if (ctl.tps_sel)
                {trn_k[l*spl+j], trn_dat[l*spl+j]} <= tps2_sym(pos_cur + 4'(j));
            else
                {trn_k[l*spl+j], trn_dat[l*spl+j]} <= {1'b0, sym_d10_2};
        end
    end
end

endmodule

`default_nettype wire

//--- hdl/dptx_lane_out.sv
/*
    DisplayPort TX lane output stage
    Picks training or main link, zeroes lanes outside the active
    lane count, then delays lane i by i extra clocks (inter-lane skew)
*/

`default_nettype none

module dptx_lane_out
    import dptx_pkg::*;
(
    input  logic        lnk_clk,
    input  logic        rst,

    // Control
    dptx_ctl_if.out     ctl,

    // Sources
    input  lane_dat_t   scrm_dat,
    input  lane_k_t     scrm_k,
    input  lane_dat_t   trn_dat,
    input  lane_k_t     trn_k,

    // PHY side
    output lane_dat_t   phy_dat,
    output lane_k_t     phy_k
);

logic [2:0] n_act;      // Active lane count

// Skewed lane outputs
logic [spl-1:0][sym_w-1:0] lane_dat_q [lanes];
logic [spl-1:0]            lane_k_q   [lanes];

always_comb
begin
    case (ctl.lanes)
        2'd1    : n_act = 3'd1;
        2'd2    : n_act = 3'd2;
        2'd3    : n_act = 3'd4;
        default : n_act = 3'd0;
    endcase
end

for (genvar l = 0; l < lanes; l++)
begin : gen_lane
    // Stage 0 is the select register, stages 1 to l the skew
    logic [spl-1:0][sym_w-1:0] pipe_dat [l+1];
    logic [spl-1:0]            pipe_k   [l+1];
    logic                      act;

    assign act = (l < n_act);

    always_ff @(posedge lnk_clk)
    begin
        if (rst)
        begin
            pipe_dat <= '{default: '0};
            pipe_k   <= '{default: '0};
        end

        else
        begin
            if (!act)
            begin
                pipe_dat[0] <= '0;      // Blanked lane
                pipe_k[0]   <= '0;
            end
            else if (ctl.trn_sel)
            begin
                pipe_dat[0] <= trn_dat[l*spl +: spl];
                pipe_k[0]   <= trn_k[l*spl +: spl];
            end
            else
            begin
                pipe_dat[0] <= scrm_dat[l*spl +: spl];
                pipe_k[0]   <= scrm_k[l*spl +: spl];
            end

            for (int s = 1; s <= l; s++)
            begin
                pipe_dat[s] <= pipe_dat[s-1];
                pipe_k[s]   <= pipe_k[s-1];
            end
        end
    end

    assign lane_dat_q[l] = pipe_dat[l];     // Last stage
    assign lane_k_q[l]   = pipe_k[l];
end

// Back to flat symbol order
always_comb
begin
    for (int l = 0; l < lanes; l++)
    begin
        for (int j = 0; j < spl; j++)
        begin
            phy_dat[l*spl+j] = lane_dat_q[l][j];
            phy_k[l*spl+j]   = lane_k_q[l][j];
        end
    end
end

endmodule

`default_nettype wire

//--- hdl/dptx_lnk.sv
/*
    DisplayPort TX link layer top
    Control message decoder, main-link scrambler and training
    generator side by side, joined in the lane output stage.
    Main link latency is 2 + i clocks on lane i
*/

`default_nettype none

module dptx_lnk
    import dptx_pkg::*;
(
    input  logic        lnk_clk,    // Link clock
    input  logic        rst,

    // Control messages
    input  logic        msg_som,
    input  logic        msg_eom,
    input  logic        msg_vld,
    input  msg_word_u   msg_dat,

    // Main link symbols
    input  lane_dat_t   main_dat,
    input  lane_k_t     main_k,

    // To PHY
    output lane_dat_t   phy_dat,
    output lane_k_t     phy_k
);

// Link settings
dptx_ctl_if ctl_if ();

lane_dat_t  scrm_dat;
lane_k_t    scrm_k;
lane_dat_t  trn_dat;
lane_k_t    trn_k;

dptx_msg_ctl msg_ctl_i
(
    .lnk_clk    (lnk_clk),
    .rst        (rst),
    .msg_som    (msg_som),
    .msg_eom    (msg_eom),
    .msg_vld    (msg_vld),
    .msg_dat    (msg_dat),
    .ctl        (ctl_if.ctl)
);

dptx_scrm scrm_i
(
    .lnk_clk    (lnk_clk),
    .rst        (rst),
    .ctl        (ctl_if.scrm),
    .main_dat   (main_dat),
    .main_k     (main_k),
    .scrm_dat   (scrm_dat),
    .scrm_k     (scrm_k)
);

dptx_trn trn_i
(
    .lnk_clk    (lnk_clk),
    .rst        (rst),
    .ctl        (ctl_if.trn),
    .trn_dat    (trn_dat),
    .trn_k      (trn_k)
);

dptx_lane_out lane_out_i
(
    .lnk_clk    (lnk_clk),
    .rst        (rst),
    .ctl        (ctl_if.out),
    .scrm_dat   (scrm_dat),
    .scrm_k     (scrm_k),
    .trn_dat    (trn_dat),
    .trn_k      (trn_k),
    .phy_dat    (phy_dat),
    .phy_k      (phy_k)
);

endmodule

`default_nettype wire

//--- test/dptx_lnk_tb.sv
/*
    DisplayPort TX link layer testbench
    Directed tests for reset TPS1, TPS2, main link with lane skew,
    scrambling with SR restart, lane count and message filtering.
    Scrambler reference model, typed compare tasks and a cycle limit
*/

`default_nettype none

module dptx_lnk_tb
    import dptx_pkg::*;
;

timeunit 1ns;
timeprecision 100ps;

localparam int max_cycles = 4000;   // Run limit in clocks
localparam int main_len   = 60;     // Clocks per main link run

logic       lnk_clk = 1'b0;
logic       rst;
logic       msg_som;
logic       msg_eom;
logic       msg_vld;
msg_word_u  msg_dat;
lane_dat_t  main_dat;
lane_k_t    main_k;
lane_dat_t  phy_dat;
lane_k_t    phy_k;

int seed = 5609;
int dat_errs = 0;
int k_errs = 0;
int other_errs = 0;
int cyc = 0;

logic [15:0] model_lfsr [lanes];    // Reference LFSR per lane
lane_dat_t   exp_dat_q [$];         // Expected scrambler output per clock
lane_k_t     exp_k_q [$];

dptx_lnk dut_i
(
    .lnk_clk    (lnk_clk),
    .rst        (rst),
    .msg_som    (msg_som),
    .msg_eom    (msg_eom),
    .msg_vld    (msg_vld),
    .msg_dat    (msg_dat),
    .main_dat   (main_dat),
    .main_k     (main_k),
    .phy_dat    (phy_dat),
    .phy_k      (phy_k)
);

always #5 lnk_clk = ~lnk_clk;   // 10 ns link clock

// Advance to 1 ns after the next rising edge
task automatic tick();
    @(posedge lnk_clk);
    #1;
endtask

task automatic check_dat(input string name, input lane_dat_t exp, input lane_dat_t act);
    if (act !== exp)
    begin
        dat_errs++;
        $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_k(input string name, input lane_k_t exp, input lane_k_t act);
    if (act !== exp)
    begin
        k_errs++;
        $display("MISMATCH at %0t ns: %s expected %b got %b", $time, name, exp, act);
    end
endtask

// One message word with vld high for one clock
task automatic send_word(input logic som, input logic eom, input msg_word_u w);
    msg_som = som;
    msg_eom = eom;
    msg_vld = 1'b1;
    msg_dat = w;
    tick();
    msg_vld = 1'b0;
    msg_som = 1'b0;
    msg_eom = 1'b0;
endtask

// Header plus value word to the control block
task automatic send_ctl(input logic [7:0] idx, input int val);
    msg_word_u w;
    w.hdr.id  = msg_id_ctl;
    w.hdr.idx = idx;
    send_word(1'b1, 1'b0, w);
    tick();                     // Idle clock between header and value
    w.dat = 16'(val);
    send_word(1'b0, 1'b1, w);
endtask

// Any header and a value word two idle clocks later
task automatic send_msg_raw(input logic [7:0] id, input logic [7:0] idx, input int val,
                            input logic hdr_eom);
    msg_word_u w;
    w.hdr.id  = id;
    w.hdr.idx = idx;
    send_word(1'b1, hdr_eom, w);
    repeat (2) tick();
    w.dat = 16'(val);
    send_word(1'b0, 1'b1, w);
endtask

// Reference scrambler for one clock of symbols in time order
task automatic model_scramble(input lane_dat_t din, input lane_k_t kin, input logic en,
                              output lane_dat_t dout);
    logic [15:0] st;
    logic [7:0]  sb;
    logic        fb;
    int          p;
    for (int l = 0; l < lanes; l++)
    begin
        st = model_lfsr[l];
        for (int j = 0; j < spl; j++)
        begin
            p = l*spl + j;
            for (int k = 0; k < 8; k++)
            begin
                fb    = st[15];     // Output bit of step k
                sb[k] = fb;
                st    = st << 1;
                st[0] = fb;
                if (fb)
                    st[5:3] = st[5:3] ^ 3'b111;
            end
            if (kin[p])
            begin
                dout[p] = din[p];
                if (din[p] == sym_sr)
                    st = scrm_seed;
            end
            else
                dout[p] = en ? (din[p] ^ sb) : din[p];
        end
        model_lfsr[l] = st;
    end
endtask

// TPS2 symbol as {k, dat} at a cycle position
function automatic logic [sym_w:0] tps2_expect(input int pos);
    if (pos == 0 || pos == 2)
        return {1'b1, sym_bs};
    else if (pos == 1 || pos == 3)
        return {1'b0, sym_d11_6};
    else
        return {1'b0, sym_d10_2};
endfunction

// Random main link word with optional SR and BS K symbols
task automatic drive_main(input int c, input logic en, input logic with_k);
    lane_dat_t din;
    lane_k_t   kin;
    lane_dat_t dout;
    for (int s = 0; s < lanes*spl; s++)
        din[s] = 8'($random(seed));
    kin = '0;
    if (with_k)
    begin
        for (int l = 0; l < lanes; l++)
        begin
            if (c % 24 == 0)
            begin
                din[l*spl] = sym_sr;    // Restart all lanes
                kin[l*spl] = 1'b1;
            end
            if (c % 7 == 3)
            begin
                din[l*spl+1] = sym_bs;
                kin[l*spl+1] = 1'b1;
            end
        end
    end
    model_scramble(din, kin, en, dout);
    main_dat = din;
    main_k   = kin;
    exp_dat_q.push_back(dout);
    exp_k_q.push_back(kin);
endtask

// Lane l shows the word driven 2 + l clocks back
task automatic check_main(input int act_lanes);
    lane_dat_t e_dat;
    lane_k_t   e_k;
    int        s;
    s = exp_dat_q.size();
    if (s >= lanes + 1)     // Last lane filled
    begin
        for (int l = 0; l < lanes; l++)
        begin
            for (int j = 0; j < spl; j++)
            begin
                e_dat[l*spl+j] = (l < act_lanes) ? exp_dat_q[s-2-l][l*spl+j] : '0;
                e_k[l*spl+j]   = (l < act_lanes) ? exp_k_q[s-2-l][l*spl+j] : 1'b0;
            end
        end
        check_dat("phy_dat", e_dat, phy_dat);
        check_k("phy_k", e_k, phy_k);
    end
endtask

task automatic run_main(input int n, input logic en, input logic with_k, input int act_lanes);
    exp_dat_q.delete();
    exp_k_q.delete();
    for (int l = 0; l < lanes; l++)
        model_lfsr[l] = scrm_seed;
    drive_main(0, en, with_k);
    for (int c = 1; c < n; c++)
    begin
        tick();
        check_main(act_lanes);
        drive_main(c, en, with_k);
    end
endtask

task automatic reset_state_tps1();
    lane_dat_t e_dat;
    for (int s = 0; s < lanes*spl; s++)
        e_dat[s] = sym_d10_2;
    repeat (lanes + 1) tick();  // Skew fill
    repeat (10)
    begin
        check_dat("phy_dat", e_dat, phy_dat);
        check_k("phy_k", '0, phy_k);
        tick();
    end
endtask

task automatic tps2_sequence();
    lane_dat_t      e_dat;
    lane_k_t        e_k;
    logic [sym_w:0] sym;
    int             found;
    int             n;
    found = 0;
    n     = 0;
    send_ctl(reg_tps_sel, 1);
    while (!found && n < 2*tps2_len)
    begin
        tick();
        n++;
        if (phy_k[0] && phy_dat[0] == sym_bs)
            found = 1;
    end
    if (!found)
    begin
        other_errs++;
        $display("No BS symbol seen on lane 0 after selecting TPS2");
    end
    else
    begin
        // t = 0 is the clock of the first BS on lane 0 and lane l lags by l
        for (int t = 1; t < lanes - 1 + 4*tps2_len/spl; t++)
        begin
            tick();
            if (t >= lanes - 1)
            begin
                for (int l = 0; l < lanes; l++)
                begin
                    for (int j = 0; j < spl; j++)
                    begin
                        sym = tps2_expect((spl*(t-l) + j) % tps2_len);
                        {e_k[l*spl+j], e_dat[l*spl+j]} = sym;
                    end
                end
                check_dat("phy_dat", e_dat, phy_dat);
                check_k("phy_k", e_k, phy_k);
            end
        end
    end
endtask

task automatic plain_main_link();
    send_ctl(reg_trn_sel, 0);
    send_ctl(reg_scrm_en, 0);
    run_main(main_len, 1'b0, 1'b0, lanes);
endtask

task automatic scramble_sr();
    send_ctl(reg_scrm_en, 1);
    run_main(main_len, 1'b1, 1'b1, lanes);
endtask

task automatic lane_count();
    send_ctl(reg_scrm_en, 0);
    send_ctl(reg_lanes, 1);
    run_main(30, 1'b0, 1'b0, 1);
    send_ctl(reg_lanes, 2);
    run_main(30, 1'b0, 1'b0, 2);
    send_ctl(reg_lanes, 3);     // Back to four lanes
endtask

task automatic msg_filtering();
    msg_word_u w;
    send_msg_raw(8'h11, reg_trn_sel, 1, 1'b0);      // Foreign ID
    send_msg_raw(msg_id_ctl, 8'd7, 1, 1'b0);        // Index out of range
    send_msg_raw(msg_id_ctl, reg_lanes, 1, 1'b1);   // Header ends the message so value is orphaned
    w.dat = 16'h0001;
    send_word(1'b0, 1'b0, w);   // Bare value word
    run_main(30, 1'b0, 1'b0, lanes);
endtask

// Cycle limit
initial
begin
    while (cyc < max_cycles)
    begin
        @(posedge lnk_clk);
        cyc++;
    end
    $display("Timeout, run stopped after %0d cycles", cyc);
    $display("sim failed");
    $finish;
end

initial
begin
    rst      = 1'b1;
    msg_som  = 1'b0;
    msg_eom  = 1'b0;
    msg_vld  = 1'b0;
    msg_dat  = '0;
    main_dat = '0;
    main_k   = '0;

    repeat (8) tick();
    rst = 1'b0;

    reset_state_tps1();
    tps2_sequence();
    plain_main_link();
    scramble_sr();
    lane_count();
    msg_filtering();

    $display("Errors: data %0d, k %0d, other %0d", dat_errs, k_errs, other_errs);
    if (dat_errs + k_errs + other_errs == 0)
        $display("sim passed");
    else
        $display("sim failed");
    $finish;
end

endmodule

`default_nettype wire

//--- sources.f
hdl/dptx_pkg.sv
hdl/dptx_ctl_if.sv
hdl/dptx_msg_ctl.sv
hdl/dptx_scrm.sv
hdl/dptx_trn.sv
hdl/dptx_lane_out.sv
hdl/dptx_lnk.sv
test/dptx_lnk_tb.sv
